// File: design/dem_uart_pkg.sv
package dem_uart_pkg;

   localparam int FLIT_WIDTH = 16;

   // one flit of a debug packet
   typedef struct packed {
      logic                  valid;
      logic                  last;
      logic [FLIT_WIDTH-1:0] data;
   } dii_flit;

   localparam logic [15:0] MOD_ID      = 16'h0002;
   localparam logic [15:0] MOD_VERSION = 16'h0000;

   // register map
   localparam logic [15:0] REG_MOD_ID      = 16'h0000;
   localparam logic [15:0] REG_MOD_VERSION = 16'h0001;
   localparam logic [15:0] REG_CONTROL     = 16'h0200;

   // header bits 15:14
   typedef enum logic [1:0] {
      TYPE_REG_REQ  = 2'b00,
      TYPE_EVENT    = 2'b01,
      TYPE_REG_RESP = 2'b10,
      TYPE_REG_ERR  = 2'b11
   } pkt_type_e;

   localparam logic [3:0] EVENT_SUBTYPE = 4'h1;

   typedef enum logic [1:0] {
      IDLE,
      SEND_SRC,
      SEND_CHAR
   } packetizer_state_e;

   typedef enum logic [3:0] {
      RX_DEST,
      RX_SRC,
      RX_HDR,
      RX_ADDR,
      RX_WDATA,
      TX_DEST,
      TX_SRC,
      TX_HDR,
      TX_DATA
   } reg_state_e;

endpackage

// File: design/dii_channel.sv
`timescale 1ns/1ps

// one flit link, valid/ready handshake
interface dii_channel;
   import dem_uart_pkg::*;

   dii_flit flit;
   logic    ready;

   modport source (
      output flit,
      input  ready
   );

   modport sink (
      input  flit,
      output ready
   );

endinterface

// File: design/uart_packetizer.sv
`timescale 1ns/1ps

module uart_packetizer (
   input  logic       clk,
   input  logic       rst,
   input  logic [9:0] id,
   input  logic [7:0] out_char,
   input  logic       out_valid,
   output logic       out_ready,
   input  logic       stall,
   dii_channel.source ev
);
   import dem_uart_pkg::*;

   packetizer_state_e     state;
   logic                  flit_valid;
   logic                  flit_last;
   logic [FLIT_WIDTH-1:0] flit_data;
   logic                  fire;

   assign fire    = flit_valid & ev.ready;
   assign ev.flit = '{valid: flit_valid, last: flit_last, data: flit_data};

   // host sees the ack only when the character flit leaves
   assign out_ready = (state == SEND_CHAR) & fire;

   // IDLE also covers the cycles where the destination flit is on offer
   always_ff @(posedge clk) begin
      if (rst) begin
         state      <= IDLE;
         flit_valid <= 1'b0;
      end else begin
         case (state)
            IDLE: begin
               if (fire) begin
                  state <= SEND_SRC;
               end else if (!flit_valid && out_valid && !stall) begin
                  flit_valid <= 1'b1;
               end
            end
            SEND_SRC: begin
               if (fire) begin
                  state <= SEND_CHAR;
               end
            end
            SEND_CHAR: begin
               if (fire) begin
                  state      <= IDLE;
                  flit_valid <= 1'b0;
               end
            end
            default: begin
               state <= IDLE;
            end
         endcase
      end
   end

   // next flit loaded as the current one transfers
   always_ff @(posedge clk) begin
      if (state == IDLE && !flit_valid) begin
         flit_data <= '0;
         flit_last <= 1'b0;
      end else if (fire) begin
         case (state)
            IDLE: begin
               flit_data <= {TYPE_EVENT, EVENT_SUBTYPE, id};
               flit_last <= 1'b0;
            end
            SEND_SRC: begin
               flit_data <= {8'h00, out_char};
               flit_last <= 1'b1;
            end
            default: begin
               flit_last <= 1'b0;
            end
         endcase
      end
   end

endmodule

// File: design/flit_fifo.sv
`timescale 1ns/1ps

module flit_fifo #(
   parameter int DEPTH = 4
) (
   input  logic       clk,
   input  logic       rst,
   dii_channel.sink   wr,
   dii_channel.source rd
);
   import dem_uart_pkg::*;

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);
   localparam logic [PTR_W-1:0] LAST_IDX = PTR_W'(DEPTH - 1);

   // last bit kept above the data
   logic [FLIT_WIDTH:0] mem [DEPTH];
   logic [PTR_W-1:0]    wr_ptr;
   logic [PTR_W-1:0]    rd_ptr;
   logic [CNT_W-1:0]    count;
   logic                wr_fire;
   logic                rd_fire;

   assign wr.ready = (count != CNT_W'(DEPTH));
   assign wr_fire  = wr.flit.valid & wr.ready;
   assign rd.flit  = '{valid: (count != '0),
                       last:  mem[rd_ptr][FLIT_WIDTH],
                       data:  mem[rd_ptr][FLIT_WIDTH-1:0]};
   assign rd_fire  = rd.flit.valid & rd.ready;

   always_ff @(posedge clk) begin
      if (wr_fire) begin
         mem[wr_ptr] <= {wr.flit.last, wr.flit.data};
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_fire) begin
            wr_ptr <= (wr_ptr == LAST_IDX) ? '0 : wr_ptr + 1'b1;
         end
         if (rd_fire) begin
            rd_ptr <= (rd_ptr == LAST_IDX) ? '0 : rd_ptr + 1'b1;
         end
         case ({wr_fire, rd_fire})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   a_wr_stable: assert property (@(posedge clk) disable iff (rst)
      wr.flit.valid && !wr.ready |=> wr.flit.valid && $stable(wr.flit))
      else $error("flit_fifo: input flit changed before transfer");

   // pointers meet only when the buffer is empty or exactly full
   a_no_overflow: assert property (@(posedge clk) disable iff (rst)
      count <= CNT_W'(DEPTH) &&
      ((wr_ptr == rd_ptr) == ((count == '0) || (count == CNT_W'(DEPTH)))))
      else $error("flit_fifo: overflow or occupancy out of step with pointers");

endmodule

// File: design/reg_access.sv
`timescale 1ns/1ps

module reg_access (
   input  logic       clk,
   input  logic       rst,
   input  logic [9:0] id,
   dii_channel.sink   req,
   dii_channel.source resp,
   output logic       stall
);
   import dem_uart_pkg::*;

   reg_state_e            state;
   logic [9:0]            src;
   logic                  is_write;
   logic                  bad;
   logic [15:0]           addr;
   logic [FLIT_WIDTH-1:0] wdata;
   logic                  rx_active;
   logic                  rx_fire;
   logic                  tx_fire;
   logic                  hdr_bad;
   logic                  hit;
   logic                  resp_err;
   logic [FLIT_WIDTH-1:0] rdata;

   assign rx_active = state inside {RX_DEST, RX_SRC, RX_HDR, RX_ADDR, RX_WDATA};
   assign req.ready = rx_active;
   assign rx_fire   = req.flit.valid & rx_active;
   assign tx_fire   = resp.flit.valid & resp.ready;

   // only read (0) and write (1) subtypes are known
   assign hdr_bad = (req.flit.data[15:14] != TYPE_REG_REQ) | (req.flit.data[13:11] != 3'b000);

   always_comb begin
      hit   = 1'b0;
      rdata = '0;
      case (addr)
         REG_MOD_ID: begin
            hit   = !is_write;
            rdata = MOD_ID;
         end
         REG_MOD_VERSION: begin
            hit   = !is_write;
            rdata = MOD_VERSION;
         end
         REG_CONTROL: begin
            hit   = 1'b1;
            rdata = {15'h0000, stall};
         end
         default: begin
            hit = 1'b0;
         end
      endcase
   end

   assign resp_err = bad | !hit;

   // TX_SRC carries the header of a response without payload
   always_comb begin
      resp.flit = '{valid: 1'b0, last: 1'b0, data: '0};
      case (state)
         TX_DEST: resp.flit = '{valid: 1'b1, last: 1'b0, data: {6'h00, src}};
         TX_HDR:  resp.flit = '{valid: 1'b1, last: 1'b0, data: {TYPE_REG_RESP, 4'h0, id}};
         TX_SRC: begin
            resp.flit = '{valid: 1'b1, last: 1'b1,
                          data: {resp_err ? TYPE_REG_ERR : TYPE_REG_RESP, 4'h0, id}};
         end
         TX_DATA: resp.flit = '{valid: 1'b1, last: 1'b1, data: rdata};
         default: resp.flit = '{valid: 1'b0, last: 1'b0, data: '0};
      endcase
   end

   // RX_SRC drains a broken packet up to its last flit
   always_ff @(posedge clk) begin
      if (rst) begin
         state <= RX_DEST;
         stall <= 1'b0;
      end else begin
         case (state)
            RX_DEST: begin
               if (rx_fire) begin
                  state <= req.flit.last ? TX_DEST : RX_HDR;
               end
            end
            RX_HDR: begin
               if (rx_fire) begin
                  if (req.flit.last) begin
                     state <= TX_DEST;
                  end else begin
                     state <= hdr_bad ? RX_SRC : RX_ADDR;
                  end
               end
            end
            RX_ADDR: begin
               if (rx_fire) begin
                  if (req.flit.last) begin
                     state <= TX_DEST;
                  end else begin
                     state <= is_write ? RX_WDATA : RX_SRC;
                  end
               end
            end
            RX_WDATA: begin
               if (rx_fire) begin
                  state <= req.flit.last ? TX_DEST : RX_SRC;
               end
            end
            RX_SRC: begin
               if (rx_fire && req.flit.last) begin
                  state <= TX_DEST;
               end
            end
            TX_DEST: begin
               if (tx_fire) begin
                  state <= (resp_err || is_write) ? TX_SRC : TX_HDR;
                  if (is_write && !resp_err) begin
                     stall <= wdata[0];
                  end
               end
            end
            TX_HDR: begin
               if (tx_fire) begin
                  state <= TX_DATA;
               end
            end
            TX_SRC, TX_DATA: begin
               if (tx_fire) begin
                  state <= RX_DEST;
               end
            end
            default: begin
               state <= RX_DEST;
            end
         endcase
      end
   end

   // request fields, bad marks a malformed packet
   always_ff @(posedge clk) begin
      if (rx_fire) begin
         case (state)
            RX_DEST: bad <= req.flit.last;
            RX_HDR: begin
               src      <= req.flit.data[9:0];
               is_write <= req.flit.data[10];
               bad      <= req.flit.last | hdr_bad;
            end
            RX_ADDR: begin
               addr <= req.flit.data;
               bad  <= is_write ? req.flit.last : !req.flit.last;
            end
            RX_WDATA: begin
               wdata <= req.flit.data;
               bad   <= !req.flit.last;
            end
            default: bad <= 1'b1;
         endcase
      end
   end

   a_req_stable: assert property (@(posedge clk) disable iff (rst)
      req.flit.valid && !req.ready |=> req.flit.valid && $stable(req.flit))
      else $error("reg_access: request flit changed before transfer");

endmodule

// File: design/packet_mux.sv
`timescale 1ns/1ps

module packet_mux (
   input  logic       clk,
   input  logic       rst,
   dii_channel.sink   in_resp,
   dii_channel.sink   in_event,
   dii_channel.source out
);

   logic lock;
   // grant held while locked
   logic sel_resp;
   // grant in effect this cycle
   logic grant_resp;
   logic fire;

   // responses win when nothing is in flight
   assign grant_resp     = lock ? sel_resp : in_resp.flit.valid;
   assign out.flit       = grant_resp ? in_resp.flit : in_event.flit;
   assign in_resp.ready  = grant_resp & out.ready;
   assign in_event.ready = !grant_resp & out.ready;
   assign fire           = out.flit.valid & out.ready;

   // lock as soon as a flit is offered so the output cannot switch under back-pressure
   always_ff @(posedge clk) begin
      if (rst) begin
         lock     <= 1'b0;
         sel_resp <= 1'b0;
      end else begin
         if (fire && out.flit.last) begin
            lock <= 1'b0;
         end else if (out.flit.valid) begin
            lock     <= 1'b1;
            sel_resp <= grant_resp;
         end
      end
   end

   a_resp_stable: assert property (@(posedge clk) disable iff (rst)
      in_resp.flit.valid && !in_resp.ready |=> in_resp.flit.valid && $stable(in_resp.flit))
      else $error("packet_mux: response flit changed before transfer");

   a_event_stable: assert property (@(posedge clk) disable iff (rst)
      in_event.flit.valid && !in_event.ready |=> in_event.flit.valid && $stable(in_event.flit))
      else $error("packet_mux: event flit changed before transfer");

   a_grant_locked: assert property (@(posedge clk) disable iff (rst)
      fire && !out.flit.last |=> grant_resp == $past(grant_resp))
      else $error("packet_mux: grant changed inside a packet");

endmodule

// File: design/dem_uart_top.sv
`timescale 1ns/1ps

module dem_uart_top (
   input  logic                                clk,
   input  logic                                rst,
   input  logic [9:0]                          id,
   input  logic [7:0]                          out_char,
   input  logic                                out_valid,
   output logic                                out_ready,
   input  logic [dem_uart_pkg::FLIT_WIDTH-1:0] debug_in_data,
   input  logic                                debug_in_last,
   input  logic                                debug_in_valid,
   output logic                                debug_in_ready,
   output logic [dem_uart_pkg::FLIT_WIDTH-1:0] debug_out_data,
   output logic                                debug_out_last,
   output logic                                debug_out_valid,
   input  logic                                debug_out_ready
);

   logic stall;

   dii_channel ev_raw ();
   dii_channel ev_q ();
   dii_channel resp ();
   dii_channel dbg_in ();
   dii_channel dbg_out ();

   // plain ports to and from the flit links
   assign dbg_in.flit = '{valid: debug_in_valid, last: debug_in_last, data: debug_in_data};
   assign debug_in_ready = dbg_in.ready;

   assign debug_out_valid = dbg_out.flit.valid;
   assign debug_out_last  = dbg_out.flit.last;
   assign debug_out_data  = dbg_out.flit.data;
   assign dbg_out.ready   = debug_out_ready;

   uart_packetizer uart_packetizer_i (
      .clk       (clk),
      .rst       (rst),
      .id        (id),
      .out_char  (out_char),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .stall     (stall),
      .ev        (ev_raw)
   );

   flit_fifo #(
      .DEPTH (4)
   ) flit_fifo_i (
      .clk (clk),
      .rst (rst),
      .wr  (ev_raw),
      .rd  (ev_q)
   );

   reg_access reg_access_i (
      .clk   (clk),
      .rst   (rst),
      .id    (id),
      .req   (dbg_in),
      .resp  (resp),
      .stall (stall)
   );

   packet_mux packet_mux_i (
      .clk      (clk),
      .rst      (rst),
      .in_resp  (resp),
      .in_event (ev_q),
      .out      (dbg_out)
   );

endmodule

// File: sim/tb_dem_uart.sv
`timescale 1ns/1ps

module tb_dem_uart;
   import dem_uart_pkg::*;

   localparam int         TIMEOUT     = 200;
   localparam int         MAX_ENTRIES = 32;
   localparam logic [9:0] DUT_ID      = 10'h155;
   localparam logic [9:0] HOST_ID     = 10'h02a;

   typedef enum logic [1:0] {
      K_CHAR,
      K_READ,
      K_WRITE,
      K_RAW
   } kind_e;

   logic        clk;
   logic        rst;
   logic [7:0]  out_char;
   logic        out_valid;
   logic        out_ready;
   logic [15:0] debug_in_data;
   logic        debug_in_last;
   logic        debug_in_valid;
   logic        debug_in_ready;
   logic [15:0] debug_out_data;
   logic        debug_out_last;
   logic        debug_out_valid;
   logic        debug_out_ready;

   // stimulus table
   // expected packet packed as {flit2, flit1, flit0} of {last, data}
   string       t_name [MAX_ENTRIES];
   kind_e       t_kind [MAX_ENTRIES];
   logic [15:0] t_addr [MAX_ENTRIES];
   logic [15:0] t_data [MAX_ENTRIES];
   logic        t_rnd  [MAX_ENTRIES];
   int          t_len  [MAX_ENTRIES];
   logic [50:0] t_exp  [MAX_ENTRIES];
   int          n_entries = 0;

   logic [16:0] exp_ev [$];
   string       name_ev [$];
   logic [16:0] exp_resp [$];
   string       name_resp [$];
   logic [16:0] cur_pkt [$];

   logic model_stall = 1'b0;
   logic rand_ready  = 1'b0;
   int   seed        = 32'h9bf0;
   int   errors      = 0;
   int   checks      = 0;
   int   chars_sent  = 0;
   int   ready_pulses = 0;
   int   event_pkts  = 0;

   dem_uart_top dem_uart_top_i (
      .clk             (clk),
      .rst             (rst),
      .id              (DUT_ID),
      .out_char        (out_char),
      .out_valid       (out_valid),
      .out_ready       (out_ready),
      .debug_in_data   (debug_in_data),
      .debug_in_last   (debug_in_last),
      .debug_in_valid  (debug_in_valid),
      .debug_in_ready  (debug_in_ready),
      .debug_out_data  (debug_out_data),
      .debug_out_last  (debug_out_last),
      .debug_out_valid (debug_out_valid),
      .debug_out_ready (debug_out_ready)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #2 clk = ~clk;
      end
   end

   function automatic logic [15:0] header(input logic [1:0] ptype, input logic [3:0] sub,
                                          input logic [9:0] src);
      return {ptype, sub, src};
   endfunction

   task automatic finish_run();
      $display("checks: %0d  errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   endtask

   task automatic timeout_abort(input string what);
      errors++;
      $display("timeout after %0d cycles: %s", TIMEOUT, what);
      finish_run();
   endtask

   // reference model of the endpoint
   // responses carry no payload unless a read succeeds
   task automatic model_packet(input kind_e kind, input logic [15:0] addr,
                               input logic [15:0] data, output int len,
                               output logic [50:0] flits);
      logic [16:0] dest;
      logic        ok;
      logic [15:0] rval;
      dest  = {1'b0, 6'h00, HOST_ID};
      ok    = 1'b0;
      rval  = '0;
      len   = 2;
      flits = '0;
      case (kind)
         K_CHAR: begin
            len   = 3;
            flits = {{1'b1, 8'h00, data[7:0]},
                     {1'b0, header(TYPE_EVENT, EVENT_SUBTYPE, DUT_ID)}, 17'h00000};
         end
         K_READ: begin
            ok = 1'b1;
            case (addr)
               REG_MOD_ID:      rval = MOD_ID;
               REG_MOD_VERSION: rval = MOD_VERSION;
               REG_CONTROL:     rval = {15'h0000, model_stall};
               default:         ok = 1'b0;
            endcase
         end
         K_WRITE: begin
            ok = (addr == REG_CONTROL);
            if (ok) begin
               model_stall = data[0];
            end
         end
         default: begin
            ok = 1'b0;
         end
      endcase
      if (kind == K_READ && ok) begin
         len   = 3;
         flits = {{1'b1, rval}, {1'b0, header(TYPE_REG_RESP, 4'h0, DUT_ID)}, dest};
      end else if (kind != K_CHAR) begin
         flits = {17'h00000, {1'b1, header(ok ? TYPE_REG_RESP : TYPE_REG_ERR, 4'h0, DUT_ID)},
                  dest};
      end
   endtask

   task automatic push_expected(input string name, input kind_e kind, input int len,
                                input logic [50:0] flits);
      int i;
      for (i = 0; i < len; i++) begin
         if (kind == K_CHAR) begin
            exp_ev.push_back(flits[i*17 +: 17]);
            name_ev.push_back(name);
         end else begin
            exp_resp.push_back(flits[i*17 +: 17]);
            name_resp.push_back(name);
         end
      end
   endtask

   task automatic add_entry(input string name, input kind_e kind, input logic [15:0] addr,
                            input logic [15:0] data, input logic rnd);
      int          len;
      logic [50:0] flits;
      model_packet(kind, addr, data, len, flits);
      t_name[n_entries] = name;
      t_kind[n_entries] = kind;
      t_addr[n_entries] = addr;
      t_data[n_entries] = data;
      t_rnd[n_entries]  = rnd;
      t_len[n_entries]  = len;
      t_exp[n_entries]  = flits;
      n_entries++;
   endtask

   task automatic fill_table();
      int i;
      add_entry("char_a", K_CHAR, 16'h0000, 16'h0041, 1'b0);
      add_entry("char_z", K_CHAR, 16'h0000, 16'h007a, 1'b0);
      add_entry("read_mod_id", K_READ, REG_MOD_ID, 16'h0000, 1'b0);
      add_entry("read_mod_version", K_READ, REG_MOD_VERSION, 16'h0000, 1'b0);
      add_entry("read_unknown", K_READ, 16'h0042, 16'h0000, 1'b0);
      add_entry("non_request", K_RAW, 16'h0000, 16'h1234, 1'b0);
      add_entry("write_version", K_WRITE, REG_MOD_VERSION, 16'h0001, 1'b0);
      for (i = 0; i < 12; i++) begin
         add_entry($sformatf("rand_char_%0d", i), K_CHAR, 16'h0000,
                   {8'h00, 8'h61 + 8'(i)}, 1'b1);
      end
      add_entry("ctrl_write_1", K_WRITE, REG_CONTROL, 16'h0001, 1'b0);
      add_entry("ctrl_read_1", K_READ, REG_CONTROL, 16'h0000, 1'b0);
   endtask

   task automatic start_char(input logic [7:0] ch);
      @(negedge clk);
      out_char  = ch;
      out_valid = 1'b1;
      chars_sent++;
   endtask

   task automatic wait_char_ack();
      int n;
      n = 0;
      @(posedge clk);
      while (!out_ready && n < TIMEOUT) begin
         @(posedge clk);
         n++;
      end
      if (!out_ready) begin
         timeout_abort("out_ready never acknowledged a character");
      end
      @(negedge clk);
      out_valid = 1'b0;
   endtask

   task automatic send_flit(input logic [15:0] data, input logic last);
      int n;
      @(negedge clk);
      debug_in_data  = data;
      debug_in_last  = last;
      debug_in_valid = 1'b1;
      n = 0;
      @(posedge clk);
      while (!debug_in_ready && n < TIMEOUT) begin
         @(posedge clk);
         n++;
      end
      if (!debug_in_ready) begin
         timeout_abort("debug_in_ready stayed low during a request");
      end
   endtask

   task automatic send_request(input kind_e kind, input logic [15:0] addr,
                               input logic [15:0] data);
      logic [1:0] ptype;
      logic [3:0] sub;
      if (kind == K_RAW) begin
         ptype = TYPE_EVENT;
      end else begin
         ptype = TYPE_REG_REQ;
      end
      sub = (kind == K_WRITE) ? 4'h1 : 4'h0;
      send_flit({6'h00, DUT_ID}, 1'b0);
      send_flit(header(ptype, sub, HOST_ID), 1'b0);
      if (kind == K_RAW) begin
         send_flit(data, 1'b1);
      end else begin
         send_flit(addr, kind == K_READ);
         if (kind == K_WRITE) begin
            send_flit(data, 1'b1);
         end
      end
      @(negedge clk);
      debug_in_valid = 1'b0;
      // response is under way now, so the request side must be closed
      checks++;
      if (debug_in_ready !== 1'b0) begin
         errors++;
         $display("[FAIL] request_in_ready: expected 0 actual %b", debug_in_ready);
      end
   endtask

   task automatic wait_drain(input string what);
      int n;
      n = 0;
      @(negedge clk);
      while ((exp_ev.size() + exp_resp.size() + cur_pkt.size()) != 0 && n < TIMEOUT) begin
         @(negedge clk);
         n++;
      end
      if ((exp_ev.size() + exp_resp.size() + cur_pkt.size()) != 0) begin
         timeout_abort({"output packets missing after ", what});
      end
   endtask

   task automatic apply_entry(input int i);
      rand_ready = t_rnd[i];
      push_expected(t_name[i], t_kind[i], t_len[i], t_exp[i]);
      if (t_kind[i] == K_CHAR) begin
         start_char(t_data[i][7:0]);
         wait_char_ack();
      end else begin
         send_request(t_kind[i], t_addr[i], t_data[i]);
      end
      wait_drain(t_name[i]);
      rand_ready = 1'b0;
   endtask

   // stall is set by the table, so the character must wait for the clearing write
   task automatic stall_hold_check();
      int          pulses;
      int          events;
      int          len;
      logic [50:0] flits;
      pulses = ready_pulses;
      events = event_pkts;
      start_char(8'h5a);
      repeat (100) @(negedge clk);
      checks++;
      if (ready_pulses != pulses) begin
         errors++;
         $display("[FAIL] stall_hold out_ready pulses: expected %0d actual %0d",
                  pulses, ready_pulses);
      end
      checks++;
      if (event_pkts != events) begin
         errors++;
         $display("[FAIL] stall_hold event packets: expected %0d actual %0d",
                  events, event_pkts);
      end
      model_packet(K_WRITE, REG_CONTROL, 16'h0000, len, flits);
      push_expected("stall_release", K_WRITE, len, flits);
      model_packet(K_CHAR, 16'h0000, 16'h005a, len, flits);
      push_expected("stall_pending_char", K_CHAR, len, flits);
      send_request(K_WRITE, REG_CONTROL, 16'h0000);
      wait_char_ack();
      wait_drain("stall_release");
   endtask

   task automatic mixed_traffic();
      logic [15:0] mix_addr [4];
      int          len;
      logic [50:0] flits;
      int          j;
      int          k;
      mix_addr[0] = REG_MOD_ID;
      mix_addr[1] = REG_CONTROL;
      mix_addr[2] = 16'h0077;
      mix_addr[3] = REG_MOD_VERSION;
      rand_ready = 1'b1;
      for (j = 0; j < 6; j++) begin
         model_packet(K_CHAR, 16'h0000, {8'h00, 8'h41 + 8'(j)}, len, flits);
         push_expected($sformatf("mix_char_%0d", j), K_CHAR, len, flits);
      end
      for (k = 0; k < 4; k++) begin
         model_packet(K_READ, mix_addr[k], 16'h0000, len, flits);
         push_expected($sformatf("mix_read_%0d", k), K_READ, len, flits);
      end
      fork
         begin
            for (j = 0; j < 6; j++) begin
               start_char(8'h41 + 8'(j));
               wait_char_ack();
            end
         end
         begin
            for (k = 0; k < 4; k++) begin
               send_request(K_READ, mix_addr[k], 16'h0000);
            end
         end
      join
      wait_drain("mixed_traffic");
      rand_ready = 1'b0;
   endtask

   // events and responses are matched against their own queues
   task automatic check_packet();
      logic        is_event;
      logic [16:0] exp;
      string       nm;
      is_event = (cur_pkt.size() > 1) && (cur_pkt[1][15:14] == TYPE_EVENT);
      if (is_event) begin
         event_pkts++;
      end
      foreach (cur_pkt[i]) begin
         if (is_event ? (exp_ev.size() == 0) : (exp_resp.size() == 0)) begin
            errors++;
            $display("output flit %h arrived while no packet was expected", cur_pkt[i]);
         end else begin
            if (is_event) begin
               exp = exp_ev.pop_front();
               nm  = name_ev.pop_front();
            end else begin
               exp = exp_resp.pop_front();
               nm  = name_resp.pop_front();
            end
            checks++;
            if (cur_pkt[i] !== exp) begin
               errors++;
               $display("[FAIL] %s flit %0d: expected %h actual %h", nm, i, exp, cur_pkt[i]);
            end
         end
      end
   endtask

   // output ready is random only in the phases that ask for it
   initial begin
      logic [31:0] rnd;
      debug_out_ready = 1'b1;
      forever begin
         @(negedge clk);
         if (rand_ready) begin
            rnd             = $random(seed);
            debug_out_ready = rnd[0];
         end else begin
            debug_out_ready = 1'b1;
         end
      end
   end

   // packet collector
   initial begin
      forever begin
         @(posedge clk);
         if (!rst && out_ready) begin
            ready_pulses++;
         end
         if (!rst && debug_out_valid && debug_out_ready) begin
            cur_pkt.push_back({debug_out_last, debug_out_data});
            if (debug_out_last) begin
               check_packet();
               cur_pkt.delete();
            end
         end
      end
   end

   initial begin
      int i;
      rst            = 1'b1;
      out_char       = 8'h00;
      out_valid      = 1'b0;
      debug_in_data  = 16'h0000;
      debug_in_last  = 1'b0;
      debug_in_valid = 1'b0;
      fill_table();
      repeat (8) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      // idle outputs straight after reset
      checks++;
      if (debug_in_ready !== 1'b1) begin
         errors++;
         $display("[FAIL] reset_in_ready: expected 1 actual %b", debug_in_ready);
      end
      checks++;
      if (debug_out_valid !== 1'b0) begin
         errors++;
         $display("[FAIL] reset_out_valid: expected 0 actual %b", debug_out_valid);
      end
      checks++;
      if (out_ready !== 1'b0) begin
         errors++;
         $display("[FAIL] reset_out_ready: expected 0 actual %b", out_ready);
      end
      for (i = 0; i < n_entries; i++) begin
         apply_entry(i);
      end
      stall_hold_check();
      mixed_traffic();
      checks++;
      if (ready_pulses != chars_sent) begin
         errors++;
         $display("[FAIL] out_ready_count: expected %0d actual %0d", chars_sent, ready_pulses);
      end
      finish_run();
   end

endmodule

// File: sources.f
design/dem_uart_pkg.sv
design/dii_channel.sv
design/uart_packetizer.sv
design/flit_fifo.sv
design/reg_access.sv
design/packet_mux.sv
design/dem_uart_top.sv
sim/tb_dem_uart.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module tb_dem_uart -f sources.f -o tb_dem_uart

./obj_dir/tb_dem_uart > sim.log 2>&1
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
   echo "simulation reported failures"
   exit 1
fi
echo "simulation finished without failures"
